//--- rtl/exu_lite_pkg.sv
/* Execution unit shared types */
`default_nettype none

package exu_lite_pkg;

  localparam int XLEN    = 32; // Data and address width
  localparam int RFIDX_W = 5;
  localparam int INSTR_W = 32;

  // RV32I major opcodes handled here
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_LOAD, // Address only
    ALU_NOP
  } alu_op_e;

  typedef struct packed {
    alu_op_e            op;
    logic [RFIDX_W-1:0] rs1idx;
    logic [RFIDX_W-1:0] rs2idx;
    logic [RFIDX_W-1:0] rdidx;
    logic               rs2en;
    logic               use_imm; // Second operand is the immediate
    logic               rdwen;   // Never set for x0
    logic [XLEN-1:0]    imm;
  } dec_info_t;

endpackage

`default_nettype wire

//--- rtl/exu_lite_ifs.sv
/* Write-back and OITF interfaces */
`timescale 1ns/100ps
`default_nettype none

// ALU result towards the final write-back
interface exu_wbck_if;
  logic                             valid;
  logic                             ready;
  logic [exu_lite_pkg::XLEN-1:0]    wdat;
  logic [exu_lite_pkg::RFIDX_W-1:0] rdidx;

  modport src (output valid, output wdat, output rdidx, input ready);
  modport sink (input valid, input wdat, input rdidx, output ready);
endinterface

// Dispatch, retire and hazard lookup of pending loads
interface exu_oitf_if;
  logic                             dis_ena;
  logic [exu_lite_pkg::RFIDX_W-1:0] dis_rdidx;
  logic                             dis_rdwen;
  logic                             full;
  logic                             empty;
  logic                             ret_ena;
  logic [exu_lite_pkg::RFIDX_W-1:0] ret_rdidx;
  logic                             ret_rdwen;
  logic                             match_rs1;
  logic                             match_rs2;
  logic                             match_rd;

  modport disp (
    output dis_ena, dis_rdidx, dis_rdwen,
    input  full, match_rs1, match_rs2, match_rd
  );
  modport oitf (
    input  dis_ena, dis_rdidx, dis_rdwen, ret_ena,
    output full, empty, ret_rdidx, ret_rdwen, match_rs1, match_rs2, match_rd
  );
  modport wbck (input empty, ret_rdidx, ret_rdwen, output ret_ena);
endinterface

`default_nettype wire

//--- rtl/exu_decode.sv
/* Instruction decode */
`timescale 1ns/100ps
`default_nettype none

module exu_decode (
  input  wire [exu_lite_pkg::INSTR_W-1:0] i_ir,
  output exu_lite_pkg::dec_info_t         o_dec
);

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  exu_lite_pkg::alu_op_e op;
  logic                  use_imm;

  assign opcode = i_ir[6:0];
  assign funct3 = i_ir[14:12];
  assign funct7 = i_ir[31:25];

  ////////////////////////////////////////////////////////////
  // Opcode classification
  always_comb begin
    op      = exu_lite_pkg::ALU_NOP;
    use_imm = 1'b0;
    case (opcode)
      exu_lite_pkg::OPC_OP: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: op = exu_lite_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: op = exu_lite_pkg::ALU_SUB;
          {7'b0000000, 3'b111}: op = exu_lite_pkg::ALU_AND;
          {7'b0000000, 3'b110}: op = exu_lite_pkg::ALU_OR;
          {7'b0000000, 3'b100}: op = exu_lite_pkg::ALU_XOR;
          {7'b0000000, 3'b010}: op = exu_lite_pkg::ALU_SLT;
          default:              op = exu_lite_pkg::ALU_NOP;
        endcase
      end
      exu_lite_pkg::OPC_OP_IMM: begin
        use_imm = 1'b1;
        case (funct3)
          3'b000:  op = exu_lite_pkg::ALU_ADD;
          3'b111:  op = exu_lite_pkg::ALU_AND;
          3'b110:  op = exu_lite_pkg::ALU_OR;
          3'b100:  op = exu_lite_pkg::ALU_XOR;
          default: op = exu_lite_pkg::ALU_NOP; // SLTI and shifts not supported
        endcase
      end
      exu_lite_pkg::OPC_LOAD: begin
        use_imm = 1'b1;
        if (funct3 == 3'b010) begin
          op = exu_lite_pkg::ALU_LOAD; // LW only
        end
      end
      default: op = exu_lite_pkg::ALU_NOP;
    endcase
  end

  always_comb begin
    o_dec.op      = op;
    o_dec.rs1idx  = i_ir[19:15];
    o_dec.rs2idx  = i_ir[24:20];
    o_dec.rdidx   = i_ir[11:7];
    o_dec.rs2en   = (opcode == exu_lite_pkg::OPC_OP) && (op != exu_lite_pkg::ALU_NOP);
    o_dec.use_imm = use_imm;
    o_dec.rdwen   = (op != exu_lite_pkg::ALU_NOP) && (i_ir[11:7] != '0); // x0 never written
    o_dec.imm     = {{(exu_lite_pkg::XLEN-12){i_ir[31]}}, i_ir[31:20]};
  end

endmodule

`default_nettype wire

//--- rtl/exu_regfile.sv
/* Integer register file */
`timescale 1ns/100ps
`default_nettype none

module exu_regfile (
  input  wire                             clk,
  input  wire                             i_rst_n,
  input  wire [exu_lite_pkg::RFIDX_W-1:0] i_rs1idx,
  input  wire [exu_lite_pkg::RFIDX_W-1:0] i_rs2idx,
  input  wire                             i_wen,
  input  wire [exu_lite_pkg::RFIDX_W-1:0] i_wdidx,
  input  wire [exu_lite_pkg::XLEN-1:0]    i_wdat,
  output logic [exu_lite_pkg::XLEN-1:0]   o_rs1,
  output logic [exu_lite_pkg::XLEN-1:0]   o_rs2
);

  localparam int NREG = 1 << exu_lite_pkg::RFIDX_W;

  logic [exu_lite_pkg::XLEN-1:0] rf_q [1:NREG-1]; // No storage behind x0

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < NREG; i++) begin
        rf_q[i] <= '0;
      end
    end else if (i_wen && (i_wdidx != '0)) begin
      rf_q[i_wdidx] <= i_wdat;
    end
  end

  assign o_rs1 = (i_rs1idx == '0) ? '0 : rf_q[i_rs1idx];
  assign o_rs2 = (i_rs2idx == '0) ? '0 : rf_q[i_rs2idx];

endmodule

`default_nettype wire

//--- rtl/exu_oitf.sv
/* Outstanding load table */
`timescale 1ns/100ps
`default_nettype none

module exu_oitf #(
  parameter int OITF_DEPTH = 2
) (
  input wire                             clk,
  input wire                             i_rst_n,
  input wire [exu_lite_pkg::RFIDX_W-1:0] i_dis_rs1idx,
  input wire [exu_lite_pkg::RFIDX_W-1:0] i_dis_rs2idx,
  input wire                             i_dis_rs2en,
  exu_oitf_if.oitf                       oitf
);

  localparam int PTR_W = $clog2(OITF_DEPTH);

  logic [PTR_W:0]                   wr_ptr_q; // MSB is the wrap bit
  logic [PTR_W:0]                   rd_ptr_q;
  logic [OITF_DEPTH-1:0]            vld_q;
  logic [OITF_DEPTH-1:0]            rdwen_q;
  logic [exu_lite_pkg::RFIDX_W-1:0] rdidx_q [OITF_DEPTH];
  logic [OITF_DEPTH-1:0]            pend;
  logic [OITF_DEPTH-1:0]            hit_rs1;
  logic [OITF_DEPTH-1:0]            hit_rs2;
  logic [OITF_DEPTH-1:0]            hit_rd;

  ////////////////////////////////////////////////////////////
  // Pointers and entry valid bits
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      vld_q    <= '0;
    end else begin
      if (oitf.dis_ena) begin
        wr_ptr_q                     <= wr_ptr_q + 1'b1;
        vld_q[wr_ptr_q[PTR_W-1:0]]   <= 1'b1;
      end
      if (oitf.ret_ena) begin
        rd_ptr_q                     <= rd_ptr_q + 1'b1;
        vld_q[rd_ptr_q[PTR_W-1:0]]   <= 1'b0; // Oldest entry leaves
      end
    end
  end

  always_ff @(posedge clk) begin
    if (oitf.dis_ena) begin
      rdidx_q[wr_ptr_q[PTR_W-1:0]] <= oitf.dis_rdidx;
      rdwen_q[wr_ptr_q[PTR_W-1:0]] <= oitf.dis_rdwen;
    end
  end

  assign oitf.empty = (wr_ptr_q == rd_ptr_q);
  assign oitf.full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W])
                   && (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

  assign oitf.ret_rdidx = rdidx_q[rd_ptr_q[PTR_W-1:0]];
  assign oitf.ret_rdwen = rdwen_q[rd_ptr_q[PTR_W-1:0]];

  ////////////////////////////////////////////////////////////
  // Destination match against the dispatching instruction
  assign pend = vld_q & rdwen_q;

  always_comb begin
    for (int i = 0; i < OITF_DEPTH; i++) begin
      hit_rs1[i] = pend[i] && (rdidx_q[i] == i_dis_rs1idx);
      hit_rs2[i] = pend[i] && (rdidx_q[i] == i_dis_rs2idx);
      hit_rd[i]  = pend[i] && (rdidx_q[i] == oitf.dis_rdidx);
    end
  end

  assign oitf.match_rs1 = |hit_rs1;
  assign oitf.match_rs2 = i_dis_rs2en & (|hit_rs2);
  assign oitf.match_rd  = oitf.dis_rdwen & (|hit_rd); // WAW

endmodule

`default_nettype wire

//--- rtl/exu_disp.sv
/* Dispatch and hazard stall */
`timescale 1ns/100ps
`default_nettype none

module exu_disp (
  input  wire                            i_valid,
  input  wire exu_lite_pkg::dec_info_t   i_dec,
  input  wire                            i_agu_ready,
  input  wire                            i_alu_ready,
  output logic                           i_ready,
  output logic                           o_alu_valid,
  output logic                           o_agu_valid,
  exu_oitf_if.disp                       oitf
);

  logic is_load;
  logic hazard;

  assign is_load = (i_dec.op == exu_lite_pkg::ALU_LOAD);

  // RAW on either source or WAW on rd against a pending load
  assign hazard = oitf.match_rs1 | oitf.match_rs2 | oitf.match_rd;

  ////////////////////////////////////////////////////////////
  // Routing
  assign o_alu_valid = i_valid & ~is_load & ~hazard;
  assign o_agu_valid = i_valid & is_load & ~hazard & ~oitf.full;

  // Entry allocated only when the load unit takes the address
  assign oitf.dis_ena   = o_agu_valid & i_agu_ready;
  assign oitf.dis_rdidx = i_dec.rdidx;
  assign oitf.dis_rdwen = i_dec.rdwen;

  always_comb begin
    if (hazard) begin
      i_ready = 1'b0;
    end else if (is_load) begin
      i_ready = i_agu_ready & ~oitf.full;
    end else begin
      i_ready = i_alu_ready; // Low while a load returns
    end
  end

endmodule

`default_nettype wire

//--- rtl/exu_alu.sv
/* Integer ALU and load address */
`timescale 1ns/100ps
`default_nettype none

module exu_alu (
  input  wire                            i_valid,
  input  wire exu_lite_pkg::dec_info_t   i_dec,
  input  wire [exu_lite_pkg::XLEN-1:0]   i_rs1,
  input  wire [exu_lite_pkg::XLEN-1:0]   i_rs2,
  output logic                           o_ready,
  output logic [exu_lite_pkg::XLEN-1:0]  o_agu_addr,
  exu_wbck_if.src                        wbck
);

  logic                          sub;
  logic [exu_lite_pkg::XLEN-1:0] op2;
  logic [exu_lite_pkg::XLEN-1:0] sum;
  logic [exu_lite_pkg::XLEN-1:0] res;

  assign op2 = i_dec.use_imm ? i_dec.imm : i_rs2;
  assign sub = (i_dec.op == exu_lite_pkg::ALU_SUB);

  // One adder for ADD, SUB and the load address
  assign sum = i_rs1 + (sub ? ~op2 : op2) + {{(exu_lite_pkg::XLEN-1){1'b0}}, sub};

  always_comb begin
    case (i_dec.op)
      exu_lite_pkg::ALU_ADD: res = sum;
      exu_lite_pkg::ALU_SUB: res = sum;
      exu_lite_pkg::ALU_AND: res = i_rs1 & op2;
      exu_lite_pkg::ALU_OR:  res = i_rs1 | op2;
      exu_lite_pkg::ALU_XOR: res = i_rs1 ^ op2;
      exu_lite_pkg::ALU_SLT: res = {{(exu_lite_pkg::XLEN-1){1'b0}},
                                    $signed(i_rs1) < $signed(op2)};
      default:               res = '0; // Loads and no-ops write nothing here
    endcase
  end

  assign wbck.valid = i_valid & i_dec.rdwen;
  assign wbck.wdat  = res;
  assign wbck.rdidx = i_dec.rdidx;
  assign o_ready    = wbck.ready;
  assign o_agu_addr = sum;

endmodule

`default_nettype wire

//--- rtl/exu_wbck.sv
/* Final write-back arbitration */
`timescale 1ns/100ps
`default_nettype none

module exu_wbck (
  input  wire                              i_lsu_valid,
  input  wire [exu_lite_pkg::XLEN-1:0]     i_lsu_wdat,
  output logic                             o_lsu_ready,
  output logic                             o_rf_wen,
  output logic [exu_lite_pkg::RFIDX_W-1:0] o_rf_wdidx,
  output logic [exu_lite_pkg::XLEN-1:0]    o_rf_wdat,
  exu_wbck_if.sink                         alu,
  exu_oitf_if.wbck                         oitf
);

  logic lsu_fire;

  assign o_lsu_ready = ~oitf.empty;
  assign lsu_fire    = i_lsu_valid & o_lsu_ready;
  assign oitf.ret_ena = lsu_fire; // Returns come back in order

  // Load return has priority over the ALU
  assign alu.ready = ~lsu_fire;

  assign o_rf_wen   = lsu_fire ? oitf.ret_rdwen : (alu.valid & alu.ready);
  assign o_rf_wdidx = lsu_fire ? oitf.ret_rdidx : alu.rdidx;
  assign o_rf_wdat  = lsu_fire ? i_lsu_wdat : alu.wdat;

endmodule

`default_nettype wire

//--- rtl/exu_lite.sv
/* Integer execution unit top */
`timescale 1ns/100ps
`default_nettype none

module exu_lite #(
  parameter int OITF_DEPTH = 2
) (
  input  wire                             clk,
  input  wire                             i_rst_n,
  // Instruction in
  input  wire                             i_valid,
  output logic                            i_ready,
  input  wire [exu_lite_pkg::INSTR_W-1:0] i_ir,
  // Load command
  output logic                            o_agu_valid,
  input  wire                             i_agu_ready,
  output logic [exu_lite_pkg::XLEN-1:0]   o_agu_addr,
  // Load return
  input  wire                             i_lsu_valid,
  output logic                            o_lsu_ready,
  input  wire [exu_lite_pkg::XLEN-1:0]    i_lsu_wdat,
  // Observation
  output logic [exu_lite_pkg::XLEN-1:0]   o_rf_rs1,
  output logic                            o_oitf_empty,
  output logic                            o_exu_active
);

  exu_lite_pkg::dec_info_t          dec;
  logic [exu_lite_pkg::XLEN-1:0]    rf_rs1;
  logic [exu_lite_pkg::XLEN-1:0]    rf_rs2;
  logic                             rf_wen;
  logic [exu_lite_pkg::RFIDX_W-1:0] rf_wdidx;
  logic [exu_lite_pkg::XLEN-1:0]    rf_wdat;
  logic                             alu_valid;
  logic                             alu_ready;

  exu_wbck_if wbck_if ();
  exu_oitf_if oitf_if ();

  ////////////////////////////////////////////////////////////
  // Decode and register read
  exu_decode u_exu_decode (
    .i_ir  (i_ir),
    .o_dec (dec)
  );

  exu_regfile u_exu_regfile (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_rs1idx (dec.rs1idx),
    .i_rs2idx (dec.rs2idx),
    .i_wen    (rf_wen),
    .i_wdidx  (rf_wdidx),
    .i_wdat   (rf_wdat),
    .o_rs1    (rf_rs1),
    .o_rs2    (rf_rs2)
  );

  ////////////////////////////////////////////////////////////
  // Dispatch and pending loads
  exu_disp u_exu_disp (
    .i_valid     (i_valid),
    .i_dec       (dec),
    .i_agu_ready (i_agu_ready),
    .i_alu_ready (alu_ready),
    .i_ready     (i_ready),
    .o_alu_valid (alu_valid),
    .o_agu_valid (o_agu_valid),
    .oitf        (oitf_if.disp)
  );

  exu_oitf #(
    .OITF_DEPTH (OITF_DEPTH)
  ) u_exu_oitf (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_dis_rs1idx (dec.rs1idx),
    .i_dis_rs2idx (dec.rs2idx),
    .i_dis_rs2en  (dec.rs2en),
    .oitf         (oitf_if.oitf)
  );

  ////////////////////////////////////////////////////////////
  // Execute and write-back
  exu_alu u_exu_alu (
    .i_valid    (alu_valid),
    .i_dec      (dec),
    .i_rs1      (rf_rs1),
    .i_rs2      (rf_rs2),
    .o_ready    (alu_ready),
    .o_agu_addr (o_agu_addr),
    .wbck       (wbck_if.src)
  );

  exu_wbck u_exu_wbck (
    .i_lsu_valid (i_lsu_valid),
    .i_lsu_wdat  (i_lsu_wdat),
    .o_lsu_ready (o_lsu_ready),
    .o_rf_wen    (rf_wen),
    .o_rf_wdidx  (rf_wdidx),
    .o_rf_wdat   (rf_wdat),
    .alu         (wbck_if.sink),
    .oitf        (oitf_if.wbck)
  );

  assign o_rf_rs1     = rf_rs1;
  assign o_oitf_empty = oitf_if.empty;
  assign o_exu_active = ~oitf_if.empty | i_valid;

endmodule

`default_nettype wire

//--- include/exu_lite_tb_ref.svh
/* Reference model functions */
`ifndef EXU_LITE_TB_REF_SVH
`define EXU_LITE_TB_REF_SVH

// Register form encoding
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

// Immediate and load forms
function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic bit ref_is_load(input logic [31:0] ir);
  return (ir[6:0] == 7'b0000011) && (ir[14:12] == 3'b010);
endfunction

// True when the instruction changes rd
function automatic bit ref_writes(input logic [31:0] ir);
  bit known;
  known = 1'b0;
  case (ir[6:0])
    7'b0110011: known = ((ir[31:25] == 7'b0000000) && (ir[14:12] inside {3'b000, 3'b111,
                         3'b110, 3'b100, 3'b010}))
                     || ((ir[31:25] == 7'b0100000) && (ir[14:12] == 3'b000));
    7'b0010011: known = ir[14:12] inside {3'b000, 3'b111, 3'b110, 3'b100};
    7'b0000011: known = (ir[14:12] == 3'b010);
    default:    known = 1'b0;
  endcase
  return known && (ir[11:7] != 5'd0);
endfunction

function automatic logic [31:0] ref_result(input logic [31:0] ir, input logic [31:0] a,
                                           input logic [31:0] b);
  logic [31:0] op2;
  op2 = (ir[6:0] == 7'b0110011) ? b : {{20{ir[31]}}, ir[31:20]};
  case (ir[14:12])
    3'b000:  return (ir[6:0] == 7'b0110011 && ir[30]) ? a - op2 : a + op2;
    3'b111:  return a & op2;
    3'b110:  return a | op2;
    3'b100:  return a ^ op2;
    3'b010:  return {31'd0, $signed(a) < $signed(op2)};
    default: return 32'd0;
  endcase
endfunction

function automatic logic [31:0] ref_load_addr(input logic [31:0] ir, input logic [31:0] a);
  return a + {{20{ir[31]}}, ir[31:20]};
endfunction

`endif

//--- verif/exu_lite_tb.sv
/* Execution unit testbench */
`timescale 1ns/100ps
`default_nettype none

module exu_lite_tb;

  `include "exu_lite_tb_ref.svh"

  localparam int DEPTH   = 2;
  localparam int TIMEOUT = 200; // Cycles per wait
  localparam logic [6:0] OPC_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LD  = 7'b0000011;

  logic        clk;
  logic        i_rst_n;
  logic        i_valid;
  logic        i_ready;
  logic [31:0] i_ir;
  logic        o_agu_valid;
  logic        i_agu_ready;
  logic [31:0] o_agu_addr;
  logic        i_lsu_valid;
  logic        o_lsu_ready;
  logic [31:0] i_lsu_wdat;
  logic [31:0] o_rf_rs1;
  logic        o_oitf_empty;
  logic        o_exu_active;

  logic [31:0] model_rf [32];
  logic [4:0]  pend_rd [$]; // Written rd of each pending load or 0
  logic [31:0] addr_q [$];  // Addresses taken by the load unit
  int          error_cnt   = 0;
  int          clash_cnt   = 0;
  int          full_cnt    = 0;
  int          hold_cycles = 0;
  int unsigned seed        = 32'h956f7eb5;

  exu_lite #(
    .OITF_DEPTH (DEPTH)
  ) i_exu_lite (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .i_ready      (i_ready),
    .i_ir         (i_ir),
    .o_agu_valid  (o_agu_valid),
    .i_agu_ready  (i_agu_ready),
    .o_agu_addr   (o_agu_addr),
    .i_lsu_valid  (i_lsu_valid),
    .o_lsu_ready  (o_lsu_ready),
    .i_lsu_wdat   (i_lsu_wdat),
    .o_rf_rs1     (o_rf_rs1),
    .o_oitf_empty (o_oitf_empty),
    .o_exu_active (o_exu_active)
  );

  always #20 clk = ~clk;

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    error_cnt++;
    $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
  endtask

  // RAW on rs1/rs2 or WAW on rd against a pending load
  function automatic bit hazard_expected(input logic [31:0] ir);
    bit uses_rs2;
    bit hit;
    uses_rs2 = (ir[6:0] == 7'b0110011) && ref_writes({ir[31:12], 5'd1, ir[6:0]});
    hit      = 1'b0;
    foreach (pend_rd[i]) begin
      if (pend_rd[i] != 5'd0) begin
        hit |= (pend_rd[i] == ir[19:15]);
        hit |= uses_rs2 && (pend_rd[i] == ir[24:20]);
        hit |= ref_writes(ir) && (pend_rd[i] == ir[11:7]);
      end
    end
    return hit;
  endfunction

  function automatic logic [31:0] rand_instr();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [2:0]  lf3;
    int          sel;
    rd  = 5'($urandom % 8); // Few registers for many hazards
    rs1 = 5'($urandom % 8);
    rs2 = 5'($urandom % 8);
    imm = 12'($urandom);
    sel = $urandom % 3;
    lf3 = (sel == 0) ? 3'b111 : (sel == 1) ? 3'b110 : 3'b100;
    case ($urandom % 10)
      0:       return enc_r(7'b0000000, 3'b000, rd, rs1, rs2);
      1:       return enc_r(7'b0100000, 3'b000, rd, rs1, rs2);
      2:       return enc_r(7'b0000000, 3'b010, rd, rs1, rs2);
      3:       return enc_r(7'b0000000, lf3, rd, rs1, rs2);
      4:       return enc_i(imm, 3'b000, rd, rs1, OPC_IMM);
      5:       return enc_i(imm, lf3, rd, rs1, OPC_IMM);
      6, 7:    return enc_i(imm, 3'b010, rd, rs1, OPC_LD);
      8:       return enc_i(imm, 3'b010, rd, rs1, OPC_IMM); // SLTI decodes as a no-op
      default: return enc_r(7'b0000001, 3'b000, rd, rs1, rs2); // MUL decodes as a no-op
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Comparison against the model and model update
  always @(negedge clk) begin : compare_outputs
    logic [31:0] ir;
    bit          fire;
    bit          haz;
    bit          room;
    bit          exp_ready;
    bit          exp_agu;
    if (i_rst_n) begin
      ir   = i_ir;
      fire = i_lsu_valid && (pend_rd.size() != 0);
      haz  = hazard_expected(ir);
      room = pend_rd.size() < DEPTH;
      exp_ready = haz ? 1'b0 : ref_is_load(ir) ? (i_agu_ready && room) : !fire;
      exp_agu   = i_valid && ref_is_load(ir) && !haz && room;
      assert (o_rf_rs1 == model_rf[ir[19:15]])
        else report_mismatch("o_rf_rs1", o_rf_rs1, model_rf[ir[19:15]]);
      assert (o_oitf_empty == (pend_rd.size() == 0))
        else report_mismatch("o_oitf_empty", o_oitf_empty, pend_rd.size() == 0);
      assert (o_lsu_ready == (pend_rd.size() != 0))
        else report_mismatch("o_lsu_ready", o_lsu_ready, pend_rd.size() != 0);
      assert (o_exu_active == ((pend_rd.size() != 0) || i_valid))
        else report_mismatch("o_exu_active", o_exu_active, (pend_rd.size() != 0) || i_valid);
      assert (o_agu_valid == exp_agu)
        else report_mismatch("o_agu_valid", o_agu_valid, exp_agu);
      if (i_valid) begin
        assert (i_ready == exp_ready) else report_mismatch("i_ready", i_ready, exp_ready);
        if (exp_agu) begin
          assert (o_agu_addr == ref_load_addr(ir, model_rf[ir[19:15]]))
            else report_mismatch("o_agu_addr", o_agu_addr, ref_load_addr(ir, model_rf[ir[19:15]]));
        end
        if (fire && !haz && !ref_is_load(ir)) clash_cnt++;
        if (ref_is_load(ir) && !room) full_cnt++;
      end
      if (fire) begin // Oldest load retires first
        if (pend_rd[0] != 5'd0) model_rf[pend_rd[0]] = i_lsu_wdat;
        void'(pend_rd.pop_front());
      end
      if (i_valid && i_ready) begin
        if (ref_is_load(ir)) begin
          pend_rd.push_back(ref_writes(ir) ? ir[11:7] : 5'd0);
          addr_q.push_back(o_agu_addr);
        end else if (ref_writes(ir)) begin
          model_rf[ir[11:7]] = ref_result(ir, model_rf[ir[19:15]], model_rf[ir[24:20]]);
        end
      end
    end
  end

  // Load unit returning in order after a random gap
  initial begin : load_responder
    int gap;
    gap = 0;
    forever begin
      @(posedge clk);
      #1;
      i_lsu_valid = 1'b0;
      i_agu_ready = ($urandom % 4) != 0;
      if (hold_cycles > 0) begin
        hold_cycles--;
      end else if (gap > 0) begin
        gap--;
      end else if (addr_q.size() != 0) begin
        void'(addr_q.pop_front());
        i_lsu_valid = 1'b1;
        i_lsu_wdat  = $urandom;
        gap         = $urandom % 4;
      end
    end
  end

  task automatic issue(input logic [31:0] ir);
    int waited;
    i_valid = 1'b1;
    i_ir    = ir;
    waited  = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!i_ready && (waited < TIMEOUT));
    if (!i_ready) begin
      $display("Timeout: instruction %h was not accepted in %0d cycles", ir, TIMEOUT);
      $display("Some tests failed");
      $finish;
    end else begin
      @(posedge clk);
      #2;
      i_valid = 1'b0;
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while ((pend_rd.size() != 0) && (waited < TIMEOUT)) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (pend_rd.size() != 0) begin
      $display("Timeout: pending loads never returned");
      $display("Some tests failed");
      $finish;
    end
  endtask

  task automatic sweep_regs();
    for (int r = 0; r < 32; r++) begin
      i_ir = {12'd0, 5'(r), 3'b000, 5'd0, 7'd0}; // rs1 field only
      @(posedge clk);
      #2;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  initial begin : main
    void'($urandom(seed));
    clk         = 1'b0;
    i_rst_n     = 1'b0;
    i_valid     = 1'b0;
    i_ir        = '0;
    i_agu_ready = 1'b1;
    i_lsu_valid = 1'b0;
    i_lsu_wdat  = '0;
    foreach (model_rf[i]) model_rf[i] = '0;
    repeat (3) @(posedge clk);
    #2;
    i_rst_n = 1'b1;
    @(negedge clk);
    assert (o_oitf_empty && !o_agu_valid && !o_lsu_ready)
      else begin
        error_cnt++;
        $display("Outputs are not idle after reset");
      end
    @(posedge clk);
    #2;
    sweep_regs();
    // Signed compare, x0 write, unsupported encoding
    issue(enc_i(12'hffb, 3'b000, 5'd1, 5'd0, OPC_IMM));
    issue(enc_i(12'h007, 3'b000, 5'd2, 5'd0, OPC_IMM));
    issue(enc_r(7'b0000000, 3'b010, 5'd3, 5'd1, 5'd2));
    issue(enc_r(7'b0000000, 3'b010, 5'd4, 5'd2, 5'd1));
    issue(enc_r(7'b0100000, 3'b000, 5'd5, 5'd1, 5'd2));
    issue(enc_i(12'h123, 3'b000, 5'd0, 5'd1, OPC_IMM));
    issue(enc_i(12'h123, 3'b010, 5'd6, 5'd1, OPC_IMM));
    sweep_regs();
    // Fill the OITF and hit both loads with a RAW
    hold_cycles = 8;
    issue(enc_i(12'h004, 3'b010, 5'd6, 5'd2, OPC_LD));
    issue(enc_i(12'hffc, 3'b010, 5'd7, 5'd5, OPC_LD));
    issue(enc_i(12'h010, 3'b010, 5'd8, 5'd0, OPC_LD));
    issue(enc_r(7'b0000000, 3'b000, 5'd9, 5'd6, 5'd7));
    drain();
    // Load return while ALU ops wait
    hold_cycles = 2;
    issue(enc_i(12'h000, 3'b010, 5'd10, 5'd0, OPC_LD));
    for (int k = 0; k < 4; k++) begin
      issue(enc_i(12'h055, 3'b110, 5'(11 + k), 5'd2, OPC_IMM));
    end
    drain();
    for (int n = 0; n < 400; n++) begin
      issue(rand_instr());
    end
    drain();
    sweep_regs();
    if (clash_cnt == 0) begin
      error_cnt++;
      $display("No ALU instruction was offered during a load return");
    end
    if (full_cnt == 0) begin
      error_cnt++;
      $display("No load was offered while the OITF was full");
    end
    $display("Errors: %0d, ALU ops against a return: %0d, loads against a full OITF: %0d",
             error_cnt, clash_cnt, full_cnt);
    if (error_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- exu_lite.f
+incdir+include
rtl/exu_lite_pkg.sv
rtl/exu_lite_ifs.sv
rtl/exu_decode.sv
rtl/exu_regfile.sv
rtl/exu_oitf.sv
rtl/exu_disp.sv
rtl/exu_alu.sv
rtl/exu_wbck.sv
rtl/exu_lite.sv
verif/exu_lite_tb.sv
